//--- hdl/execPkg.sv
package execPkg;

  localparam int maxLatency = 4;
  localparam int latWidth = $clog2(maxLatency + 1);

  typedef logic [5:0] regIdx_t;
  typedef logic [31:0] word_t;
  typedef logic [latWidth-1:0] lat_t;

  typedef enum logic [6:0] {
    fAdd   = 7'b1000000,
    fSub   = 7'b1000001,
    fMul   = 7'b1000010,
    fDiv   = 7'b1000011,
    fEq    = 7'b1000100,
    fLt    = 7'b1000101,
    fLe    = 7'b1000110,
    fSqrt  = 7'b1000111,
    fCvtWS = 7'b1001111,
    fCvtSW = 7'b1010111
  } fpuOp_e;

  typedef struct packed {
    logic       isFpu;
    logic [5:0] func;
  } aluRoute_t;

  // one control word, read as an FPU opcode or as routing bits
  typedef union packed {
    fpuOp_e    op;
    aluRoute_t route;
  } aluCtrl_u;

  typedef struct packed {
    aluCtrl_u ctrl;
    regIdx_t  rd;
    regIdx_t  rs1;
    regIdx_t  rs2;
    word_t    aluResult;
  } issue_t;

  // bit order follows the FPU bus with the add result in the low word
  typedef struct packed {
    word_t cvtSWRes;
    word_t cvtWSRes;
    logic  ltBit;
    logic  leBit;
    logic  eqBit;
    word_t sqrtRes;
    word_t divRes;
    word_t mulRes;
    word_t subRes;
    word_t addRes;
  } fpuResults_t;

  typedef struct packed {
    regIdx_t rd;
    word_t   data;
  } writeback_t;

  function automatic lat_t fpuLatency(fpuOp_e op);
    case (op)
      fAdd, fSub, fSqrt:    return lat_t'(3);
      fMul, fCvtWS, fCvtSW: return lat_t'(2);
      fDiv:                 return lat_t'(4);
      default:              return lat_t'(1);
    endcase
  endfunction

  function automatic word_t fpuSelect(fpuOp_e op, fpuResults_t res);
    case (op)
      fAdd:    return res.addRes;
      fSub:    return res.subRes;
      fMul:    return res.mulRes;
      fDiv:    return res.divRes;
      fSqrt:   return res.sqrtRes;
      fEq:     return {31'b0, res.eqBit};
      fLt:     return {31'b0, res.ltBit};
      fLe:     return {31'b0, res.leBit};
      fCvtWS:  return res.cvtWSRes;
      fCvtSW:  return res.cvtSWRes;
      default: return '0;
    endcase
  endfunction

endpackage

//--- hdl/fpuLatencyTimer.sv
`timescale 1ns/1ns

module fpuLatencyTimer (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  execPkg::aluCtrl_u op,
  output logic              busy,
  output logic              done
);
  import execPkg::*;

  lat_t count;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      count <= '0;
    end else if (start) begin
      busy <= 1'b1;
      // single-cycle ops are done right after the load
      count <= fpuLatency(op.op) - lat_t'(1);
    end else if (busy) begin
      if (count == '0) begin
        busy <= 1'b0;
      end else begin
        count <= count - lat_t'(1);
      end
    end
  end

  assign done = busy && (count == '0);

  // the owning slot must be empty and idle before it takes a new op
  startWhenIdle: assert property (
    @(posedge clk) disable iff (rst)
    start |-> !busy
  );

endmodule

//--- hdl/resultSlot.sv
`timescale 1ns/1ns

module resultSlot (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 alloc,
  input  logic                 drain,
  input  logic                 accept,
  input  execPkg::issue_t      issue,
  input  execPkg::fpuResults_t fpuResults,
  output logic                 pending,
  output logic                 valid,
  output execPkg::regIdx_t     rd,
  output execPkg::word_t       result
);
  import execPkg::*;

  typedef enum logic [1:0] {
    slotEmpty,
    slotPending,
    slotValid
  } slotState_e;

  slotState_e state;
  aluCtrl_u   opReg;
  word_t      resultReg;
  logic       cancel;
  logic       finishing;
  logic       timerBusy;
  logic       timerDone;

  // a younger write to the same register makes this result dead
  assign cancel = accept && (issue.rd != '0) && (issue.rd == rd) && !alloc &&
                  (state != slotEmpty);

  assign finishing = (state == slotPending) && timerDone;

  // cancel also stops a countdown still in flight
  fpuLatencyTimer timer (
    .clk  (clk),
    .rst  (rst || cancel),
    .start(alloc && issue.ctrl.route.isFpu),
    .op   (issue.ctrl),
    .busy (timerBusy),
    .done (timerDone)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= slotEmpty;
    end else if (alloc) begin
      state <= issue.ctrl.route.isFpu ? slotPending : slotValid;
    end else if (drain || cancel) begin
      state <= slotEmpty;
    end else if (finishing) begin
      state <= slotValid;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc) begin
      rd <= issue.rd;
      opReg <= issue.ctrl;
      resultReg <= issue.aluResult;
    end else if (finishing) begin
      resultReg <= fpuSelect(opReg.op, fpuResults);
    end
  end

  assign pending = (state == slotPending) && !timerDone;
  assign valid = (state == slotValid) || finishing;

  // in the finishing cycle the value comes straight off the FPU bus
  assign result = (state == slotValid) ? resultReg : fpuSelect(opReg.op, fpuResults);

  drainOnlyValid: assert property (
    @(posedge clk) disable iff (rst)
    drain |-> valid
  );

  allocOnlyEmpty: assert property (
    @(posedge clk) disable iff (rst)
    alloc |-> (state == slotEmpty) && !timerBusy
  );

endmodule

//--- hdl/forwardUnit.sv
`timescale 1ns/1ns

module forwardUnit #(
  parameter int numSlots = 2
) (
  input  execPkg::issue_t  issue,
  input  logic [numSlots-1:0] slotPending,
  input  logic [numSlots-1:0] slotValid,
  input  execPkg::regIdx_t slotRd [numSlots],
  input  execPkg::word_t   slotResult [numSlots],
  output logic             matchA,
  output logic             matchB,
  output execPkg::word_t   fwdA,
  output execPkg::word_t   fwdB,
  output logic             hazard
);

  logic [numSlots-1:0] hitA;
  logic [numSlots-1:0] hitB;
  logic [numSlots-1:0] waitA;
  logic [numSlots-1:0] waitB;

  always_comb begin
    for (int i = 0; i < numSlots; i++) begin
      hitA[i] = slotValid[i] && (issue.rs1 != '0) && (issue.rs1 == slotRd[i]);
      hitB[i] = slotValid[i] && (issue.rs2 != '0) && (issue.rs2 == slotRd[i]);
      waitA[i] = slotPending[i] && (issue.rs1 != '0) && (issue.rs1 == slotRd[i]);
      waitB[i] = slotPending[i] && (issue.rs2 != '0) && (issue.rs2 == slotRd[i]);
    end
  end

  // scan downward so the lowest matching slot wins
  always_comb begin
    fwdA = '0;
    fwdB = '0;
    for (int i = numSlots - 1; i >= 0; i--) begin
      if (hitA[i]) begin
        fwdA = slotResult[i];
      end
      if (hitB[i]) begin
        fwdB = slotResult[i];
      end
    end
  end

  assign matchA = |hitA;
  assign matchB = |hitB;

  // a source still waiting on the FPU
  assign hazard = |{waitA, waitB};

endmodule

//--- hdl/writebackSelect.sv
`timescale 1ns/1ns

module writebackSelect #(
  parameter int numSlots = 2
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                issueEn,
  input  logic                wbHold,
  input  logic                hazard,
  input  execPkg::issue_t     issue,
  input  logic [numSlots-1:0] slotPending,
  input  logic [numSlots-1:0] slotValid,
  input  execPkg::regIdx_t    slotRd [numSlots],
  input  execPkg::word_t      slotResult [numSlots],
  output logic [numSlots-1:0] alloc,
  output logic [numSlots-1:0] drain,
  output logic                accept,
  output logic                stall,
  output execPkg::writeback_t wb
);
  import execPkg::*;

  logic [numSlots-1:0] free;
  logic [numSlots-1:0] allocPick;
  logic [numSlots-1:0] killed;
  logic [numSlots-1:0] drainable;
  logic [numSlots-1:0] drainPick;
  logic                isFpu;
  logic                bypass;
  logic                needSlot;
  logic                slotBlock;
  logic                sameRd;
  writeback_t          wbNext;

  assign isFpu = issue.ctrl.route.isFpu;
  assign free = ~(slotPending | slotValid);

  // integer result goes straight to wb when nothing older is waiting to drain
  assign bypass = !isFpu && (issue.rd != '0) && !wbHold && !(|slotValid);
  assign needSlot = isFpu || ((issue.rd != '0) && !bypass);
  assign slotBlock = needSlot && !(|free);

  assign stall = issueEn && (hazard || slotBlock);
  assign accept = issueEn && !stall;

  // lowest set bit
  assign allocPick = free & (~free + 1'b1);
  assign alloc = (accept && needSlot) ? allocPick : '0;

  // results overwritten by the accepted op are not written back
  always_comb begin
    for (int i = 0; i < numSlots; i++) begin
      killed[i] = accept && (issue.rd != '0) && (slotRd[i] == issue.rd);
    end
  end

  assign drainable = slotValid & ~killed;
  assign drainPick = drainable & (~drainable + 1'b1);
  assign drain = wbHold ? '0 : drainPick;

  always_comb begin
    wbNext = '0;
    for (int i = 0; i < numSlots; i++) begin
      if (drain[i]) begin
        wbNext.rd = slotRd[i];
        wbNext.data = slotResult[i];
      end
    end
    if (bypass && accept) begin
      wbNext.rd = issue.rd;
      wbNext.data = issue.aluResult;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb <= '0;
    end else if (!wbHold) begin
      wb <= wbNext;
    end
  end

  // cancellation leaves at most one live result per register
  always_comb begin
    sameRd = 1'b0;
    for (int i = 0; i < numSlots; i++) begin
      for (int j = i + 1; j < numSlots; j++) begin
        if (!free[i] && !free[j] && (slotRd[i] != '0) && (slotRd[i] == slotRd[j])) begin
          sameRd = 1'b1;
        end
      end
    end
  end

  oneHotPicks: assert property (
    @(posedge clk) disable iff (rst)
    $onehot0(alloc) && $onehot0(drain)
  );

  uniqueDest: assert property (
    @(posedge clk) disable iff (rst)
    !sameRd
  );

endmodule

//--- hdl/executeLine.sv
`timescale 1ns/1ns

module executeLine #(
  parameter int numSlots = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issueEn,
  input  execPkg::issue_t      issue,
  input  execPkg::fpuResults_t fpuResults,
  input  logic                 wbHold,
  output logic                 stall,
  output logic                 matchA,
  output logic                 matchB,
  output execPkg::word_t       fwdA,
  output execPkg::word_t       fwdB,
  output execPkg::writeback_t  wb
);
  import execPkg::*;

  logic [numSlots-1:0] alloc;
  logic [numSlots-1:0] drain;
  logic [numSlots-1:0] slotPending;
  logic [numSlots-1:0] slotValid;
  regIdx_t             slotRd [numSlots];
  word_t               slotResult [numSlots];
  logic                accept;
  logic                hazard;

  for (genvar i = 0; i < numSlots; i++) begin : slotGen
    resultSlot slot (
      .clk       (clk),
      .rst       (rst),
      .alloc     (alloc[i]),
      .drain     (drain[i]),
      .accept    (accept),
      .issue     (issue),
      .fpuResults(fpuResults),
      .pending   (slotPending[i]),
      .valid     (slotValid[i]),
      .rd        (slotRd[i]),
      .result    (slotResult[i])
    );
  end

  forwardUnit #(
    .numSlots(numSlots)
  ) fwd (
    .issue      (issue),
    .slotPending(slotPending),
    .slotValid  (slotValid),
    .slotRd     (slotRd),
    .slotResult (slotResult),
    .matchA     (matchA),
    .matchB     (matchB),
    .fwdA       (fwdA),
    .fwdB       (fwdB),
    .hazard     (hazard)
  );

  writebackSelect #(
    .numSlots(numSlots)
  ) wbSel (
    .clk        (clk),
    .rst        (rst),
    .issueEn    (issueEn),
    .wbHold     (wbHold),
    .hazard     (hazard),
    .issue      (issue),
    .slotPending(slotPending),
    .slotValid  (slotValid),
    .slotRd     (slotRd),
    .slotResult (slotResult),
    .alloc      (alloc),
    .drain      (drain),
    .accept     (accept),
    .stall      (stall),
    .wb         (wb)
  );

endmodule

//--- bench/clkGen.sv
`timescale 1ns/1ns

module clkGen #(
  parameter int halfPeriod = 2,
  parameter int resetCycles = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  // reset drops on a rising edge so the DUT sees it synchronously
  initial begin
    rst = 1'b1;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- bench/executeLineTb.sv
`timescale 1ns/1ns

module executeLineTb;
  import execPkg::*;

  typedef struct {
    int         test;
    logic       hold;
    logic       dropHold;
    issue_t     issue;
    logic       expStall;
    logic [1:0] expMatch;
    logic [6:0] fwdCode;
    int         wbAt;
  } row_t;

  typedef struct {
    int         cycle;
    writeback_t wb;
  } wbEvent_t;

  localparam int waitLimit = 24;

  logic        clk;
  logic        rst;
  logic        issueEn;
  issue_t      issue;
  fpuResults_t fpuResults;
  logic        wbHold;
  logic        stall;
  logic        matchA;
  logic        matchB;
  word_t       fwdA;
  word_t       fwdB;
  writeback_t  wb;

  row_t        rows[$];
  string       testNames[$];
  wbEvent_t    seen[$];
  wbEvent_t    expected[$];
  wbEvent_t    seenEv;
  writeback_t  lastWb = '0;
  logic [31:0] lcgState = 32'h5431_7b33;
  int          cycle = 0;
  logic        loaded = 1'b0;
  int          errors = 0;
  int          checks = 0;
  logic        aborted = 1'b0;

  clkGen clocks (.clk(clk), .rst(rst));

  executeLine #(.numSlots(2)) dut (
    .clk(clk), .rst(rst), .issueEn(issueEn), .issue(issue), .fpuResults(fpuResults),
    .wbHold(wbHold), .stall(stall), .matchA(matchA), .matchB(matchB),
    .fwdA(fwdA), .fwdB(fwdB), .wb(wb)
  );

  // wb only loads at edges where wbHold was low
  always @(posedge clk) begin
    cycle <= cycle + 1;
    loaded <= !wbHold;
  end

  always @(negedge clk) begin
    if (!rst) begin
      if (loaded && wb.rd != '0) begin
        seenEv.cycle = cycle;
        seenEv.wb = wb;
        seen.push_back(seenEv);
      end
      if (!loaded && wb !== lastWb) begin
        $display("Error wb: got %h while held, expected %h", wb, lastWb);
        errors++;
      end
      lastWb = wb;
    end
  end

  task automatic checkFlag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkWord(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      $display("Error %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkWb(string name, writeback_t got, writeback_t exp);
    checks++;
    if (got !== exp) begin
      $display("Error %s: got rd %h data %h, expected rd %h data %h",
               name, got.rd, got.data, exp.rd, exp.data);
      errors++;
    end
  endtask

  // integer codes carry their own result, FPU codes pick a bus field
  function automatic word_t expectedResult(logic [6:0] code, word_t lit, fpuResults_t f);
    if (!code[6]) begin
      return lit;
    end
    case (code)
      fAdd:    return f.addRes;
      fSub:    return f.subRes;
      fMul:    return f.mulRes;
      fDiv:    return f.divRes;
      fSqrt:   return f.sqrtRes;
      fCvtWS:  return f.cvtWSRes;
      fCvtSW:  return f.cvtSWRes;
      fEq:     return word_t'(f.eqBit);
      fLt:     return word_t'(f.ltBit);
      fLe:     return word_t'(f.leBit);
      default: return '0;
    endcase
  endfunction

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic fpuResults_t makeFill();
    fpuResults_t f;
    logic [31:0] bits;
    f.addRes = lcgNext();
    f.subRes = lcgNext();
    f.mulRes = lcgNext();
    f.divRes = lcgNext();
    f.sqrtRes = lcgNext();
    f.cvtWSRes = lcgNext();
    f.cvtSWRes = lcgNext();
    bits = lcgNext();
    f.eqBit = bits[7];
    f.ltBit = bits[15];
    f.leBit = bits[23];
    return f;
  endfunction

  task automatic addRow(logic hold, logic dropHold, logic [6:0] ctrl, regIdx_t rd,
                        regIdx_t rs1, regIdx_t rs2, word_t alu, logic expStall,
                        logic [1:0] expMatch, logic [6:0] fwdCode, int wbAt);
    row_t r;
    r.test = testNames.size() - 1;
    r.hold = hold;
    r.dropHold = dropHold;
    r.issue.ctrl.route = ctrl;
    r.issue.rd = rd;
    r.issue.rs1 = rs1;
    r.issue.rs2 = rs2;
    r.issue.aluResult = alu;
    r.expStall = expStall;
    r.expMatch = expMatch;
    r.fwdCode = fwdCode;
    r.wbAt = wbAt;
    rows.push_back(r);
  endtask

  // wbAt counts cycles from the accepting sample, -1 means no writeback
  task automatic buildTable();
    fpuOp_e codes [10];
    int     lat [10];
    codes = '{fAdd, fSub, fMul, fDiv, fEq, fLt, fLe, fSqrt, fCvtWS, fCvtSW};
    lat = '{3, 3, 2, 4, 1, 1, 1, 3, 2, 2};
    testNames.push_back("integer bypass");
    addRow(0, 0, 7'h05, 6'd5, 6'd0, 6'd0, 32'h1234_5678, 0, 2'b00, 7'h00, 1);
    addRow(0, 0, 7'h06, 6'd0, 6'd0, 6'd0, 32'hdead_beef, 0, 2'b00, 7'h00, -1);
    addRow(0, 0, 7'h07, 6'd6, 6'd0, 6'd0, 32'h0bad_f00d, 0, 2'b00, 7'h00, 1);
    for (int i = 0; i < 10; i++) begin
      testNames.push_back({"fpu ", codes[i].name()});
      addRow(0, 0, codes[i], 6'(33 + i), 6'd0, 6'd0, 32'hffff_ffff, 0, 2'b00, 7'h00, lat[i] + 1);
    end
    testNames.push_back("operand hazard");
    addRow(0, 0, fSqrt, 6'd40, 6'd0, 6'd0, 32'hffff_ffff, 0, 2'b00, 7'h00, 4);
    addRow(0, 0, 7'h01, 6'd7, 6'd40, 6'd0, 32'h0000_0777, 1, 2'b01, fSqrt, 2);
    addRow(0, 0, fMul, 6'd41, 6'd0, 6'd0, 32'hffff_ffff, 0, 2'b00, 7'h00, 3);
    addRow(0, 0, 7'h02, 6'd8, 6'd0, 6'd41, 32'h0000_0888, 1, 2'b10, fMul, 2);
    testNames.push_back("cancel by younger write");
    addRow(0, 0, fDiv, 6'd12, 6'd0, 6'd0, 32'hffff_ffff, 0, 2'b00, 7'h00, -1);
    addRow(0, 0, 7'h03, 6'd12, 6'd0, 6'd0, 32'hc0ff_ee00, 0, 2'b00, 7'h00, 1);
    testNames.push_back("writeback hold");
    addRow(0, 0, 7'h04, 6'd19, 6'd0, 6'd0, 32'h1919_1919, 0, 2'b00, 7'h00, 1);
    addRow(1, 0, 7'h04, 6'd20, 6'd0, 6'd0, 32'h2020_2020, 0, 2'b00, 7'h00, 4);
    addRow(1, 0, fAdd, 6'd21, 6'd0, 6'd0, 32'hffff_ffff, 0, 2'b00, 7'h00, 4);
    addRow(1, 1, 7'h04, 6'd22, 6'd0, 6'd0, 32'h2222_2222, 1, 2'b00, 7'h00, 2);
  endtask

  task automatic runRow(row_t r);
    int       waited;
    wbEvent_t ev;
    @(negedge clk);
    issue = r.issue;
    issueEn = 1'b1;
    wbHold = r.hold;
    #1;
    checkFlag("stall", stall, r.expStall);
    if (r.dropHold) begin
      @(negedge clk);
      wbHold = 1'b0;
      #1;
    end
    waited = 0;
    while (stall && !aborted) begin
      @(negedge clk);
      #1;
      waited++;
      if (waited > waitLimit) begin
        $display("timeout: operation to register %0d was never accepted", r.issue.rd);
        errors++;
        aborted = 1'b1;
      end
    end
    if (!aborted) begin
      checkFlag("matchA", matchA, r.expMatch[0]);
      checkFlag("matchB", matchB, r.expMatch[1]);
      if (r.expMatch[0]) begin
        checkWord("fwdA", fwdA, expectedResult(r.fwdCode, '0, fpuResults));
      end
      if (r.expMatch[1]) begin
        checkWord("fwdB", fwdB, expectedResult(r.fwdCode, '0, fpuResults));
      end
      if (r.wbAt >= 0) begin
        ev.cycle = cycle + r.wbAt;
        ev.wb.rd = r.issue.rd;
        ev.wb.data = expectedResult(r.issue.ctrl, r.issue.aluResult, fpuResults);
        expected.push_back(ev);
      end
    end
  endtask

  task automatic finishTest();
    int waited;
    int idx;
    @(negedge clk);
    issueEn = 1'b0;
    wbHold = 1'b0;
    #1;
    waited = 0;
    while (seen.size() < expected.size() && !aborted) begin
      @(negedge clk);
      #1;
      waited++;
      if (waited > waitLimit) begin
        $display("timeout: expected writebacks did not all arrive");
        errors++;
        aborted = 1'b1;
      end
    end
    // a few idle cycles so a stray writeback still shows up
    repeat (3) @(negedge clk);
    #1;
    foreach (expected[i]) begin
      idx = -1;
      foreach (seen[k]) begin
        if (seen[k].cycle == expected[i].cycle) begin
          idx = k;
        end
      end
      if (idx < 0) begin
        $display("missing writeback to register %0d in cycle %0d",
                 expected[i].wb.rd, expected[i].cycle);
        errors++;
      end else begin
        checkWb("wb", seen[idx].wb, expected[i].wb);
        seen.delete(idx);
      end
    end
    foreach (seen[k]) begin
      $display("unexpected writeback to register %0d in cycle %0d", seen[k].wb.rd, seen[k].cycle);
      errors++;
    end
  endtask

  initial begin
    int waited;
    int next;
    int startErrors;
    issueEn = 1'b0;
    issue = '0;
    fpuResults = '0;
    wbHold = 1'b0;
    buildTable();
    @(negedge clk);
    waited = 0;
    while (rst && !aborted) begin
      @(negedge clk);
      waited++;
      if (waited > waitLimit) begin
        $display("timeout: reset was never released");
        errors++;
        aborted = 1'b1;
      end
    end
    #1;
    checkFlag("stall", stall, 1'b0);
    checkWb("wb", wb, '0);
    next = 0;
    for (int t = 0; t < testNames.size() && !aborted; t++) begin
      startErrors = errors;
      // bus values stay fixed for the whole test
      @(negedge clk);
      fpuResults = makeFill();
      #1;
      seen.delete();
      expected.delete();
      while (next < rows.size() && rows[next].test == t && !aborted) begin
        runRow(rows[next]);
        next++;
      end
      finishTest();
      $display("test %0d %s: %0d errors", t, testNames[t], errors - startErrors);
    end
    $display("%0d tests, %0d checks, %0d errors", testNames.size(), checks, errors);
    if (errors == 0 && !aborted) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- executeLine.f
hdl/execPkg.sv
hdl/fpuLatencyTimer.sv
hdl/resultSlot.sv
hdl/forwardUnit.sv
hdl/writebackSelect.sv
hdl/executeLine.sv
bench/clkGen.sv
bench/executeLineTb.sv

//--- Bender.yml
package:
  name: executeLine

sources:
  - hdl/execPkg.sv
  - hdl/fpuLatencyTimer.sv
  - hdl/resultSlot.sv
  - hdl/forwardUnit.sv
  - hdl/writebackSelect.sv
  - hdl/executeLine.sv
  - target: test
    files:
      - bench/clkGen.sv
      - bench/executeLineTb.sv
